//--- build.f
rtl/wb_pkg.sv
rtl/wb_fifo_if.sv
rtl/wb_result_fifo.sv
rtl/wb_dispatch.sv
rtl/wb_commit_arbiter.sv
rtl/wb_top.sv
test/tb_wb_top.sv

//--- rtl/wb_commit_arbiter.sv
// in-order commit arbiter
`timescale 1ns/1ns
`default_nettype none

module wb_commit_arbiter (
    input  wire                          clk,
    input  wire                          rst_n,
    wb_fifo_if.consumer                  lanes [wb_pkg::NUM_LANES],
    output logic                         wb_valid_o,
    output logic                         wb_we_o,
    output logic [wb_pkg::ADDR_W-1:0]    wb_addr_o,
    output logic [wb_pkg::DATA_W-1:0]    wb_data_o,
    output logic [wb_pkg::CID_W-1:0]     wb_cid_o
);
    import wb_pkg::*;

    logic [CID_W-1:0]       exp_cid;            // next id allowed to retire
    wb_entry_t              head [NUM_LANES];   // lane heads
    logic [NUM_LANES-1:0]   lane_empty;
    logic [NUM_LANES-1:0]   match;              // head carries exp_cid
    logic                   hit;                // a retirement this cycle
    wb_entry_t              sel_entry;          // winning head

    // per-lane compare and pop
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign head[g]       = lanes[g].head_entry;
        assign lane_empty[g] = lanes[g].empty;
        assign match[g]      = !lane_empty[g] && (head[g].cid == exp_cid);
        assign lanes[g].pop  = match[g];  // pop in the cycle of the match
    end

    assign hit = |match;

    // select the matching head
    always_comb begin
        sel_entry = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (match[i]) begin
                sel_entry = head[i];
            end
        end
    end

    // control regs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_cid    <= '0;
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= hit;                                  // one beat per retire
            wb_we_o    <= hit && (sel_entry.op == WB_OP_WRITE);
            if (hit) begin
                exp_cid <= exp_cid + CID_W'(1);                 // wraps 15 -> 0
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (hit) begin
            wb_addr_o <= sel_entry.addr;
            wb_data_o <= sel_entry.data;
            wb_cid_o  <= sel_entry.cid;
        end
    end

    // commit ids in flight are unique, so only one lane can match
    a_single_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(match)
    ) else $error("several lane heads match commit id %0d", exp_cid);

endmodule

`default_nettype wire

//--- rtl/wb_dispatch.sv
// result stream dispatcher
`timescale 1ns/1ns
`default_nettype none

module wb_dispatch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          res_valid_i,
    input  wire [wb_pkg::LANE_W-1:0]     res_lane_i,
    input  wire wb_pkg::wb_op_e          res_op_i,
    input  wire [wb_pkg::ADDR_W-1:0]     res_addr_i,
    input  wire [wb_pkg::DATA_W-1:0]     res_data_i,
    input  wire [wb_pkg::CID_W-1:0]      res_cid_i,
    output logic                         res_stall_o,
    wb_fifo_if.producer                  lanes [wb_pkg::NUM_LANES]
);
    import wb_pkg::*;

    wb_entry_t              entry;      // packed result
    logic [NUM_LANES-1:0]   lane_sel;   // one-hot target lane
    logic [NUM_LANES-1:0]   lane_full;  // per-lane full flags

    // pack incoming fields
    always_comb begin
        entry.op   = res_op_i;
        entry.addr = res_addr_i;
        entry.data = res_data_i;
        entry.cid  = res_cid_i;
    end

    // lane decode, push only into a lane with room
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lane_sel[g]         = res_valid_i && (res_lane_i == LANE_W'(g));
        assign lane_full[g]        = lanes[g].full;
        assign lanes[g].push       = lane_sel[g] && !lane_full[g];
        assign lanes[g].push_entry = entry;   // same payload to all lanes
    end

    // stall when the addressed lane is full, source holds the result
    assign res_stall_o = |(lane_sel & lane_full);

    // source must address an existing lane
    a_lane_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid_i |-> (res_lane_i < LANE_W'(NUM_LANES))
    ) else $error("result addressed to lane %0d, out of range", res_lane_i);

    // stalled result stays put until accepted
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid_i && res_stall_o) |=>
            (res_valid_i && $stable(res_lane_i) && $stable(res_cid_i))
    ) else $error("result changed under stall");

endmodule

`default_nettype wire

//--- rtl/wb_fifo_if.sv
// lane fifo push and pop bundle
`timescale 1ns/1ns
`default_nettype none

interface wb_fifo_if;
    import wb_pkg::*;

    // push side
    logic       push;        // write strobe, only when !full
    wb_entry_t  push_entry;
    logic       full;

    // pop side
    wb_entry_t  head_entry;  // valid while !empty
    logic       empty;
    logic       pop;         // read strobe, only when !empty

    // dispatcher end
    modport producer (output push, output push_entry, input full);

    // the fifo itself
    modport fifo (
        input  push, input push_entry, input pop,
        output full, output head_entry, output empty
    );

    // commit arbiter end
    modport consumer (output pop, input head_entry, input empty);

endinterface

`default_nettype wire

//--- rtl/wb_pkg.sv
// writeback stage shared definitions
`default_nettype none

package wb_pkg;

    // lane and fifo geometry
    localparam int NUM_LANES  = 3;                  // execution lanes
    localparam int LANE_W     = 2;                  // lane index bits
    localparam int FIFO_DEPTH = 2;                  // entries per lane fifo
    localparam int PTR_W      = $clog2(FIFO_DEPTH); // fifo pointer bits
    localparam int CNT_W      = PTR_W + 1;          // holds 0..FIFO_DEPTH

    // result payload widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;    // 32 architectural regs
    localparam int CID_W  = 4;    // commit id, wraps mod 16

    // result kind
    typedef enum logic [0:0] {
        WB_OP_WRITE   = 1'b1,     // writes rd
        WB_OP_NOWRITE = 1'b0      // store, branch, retire only
    } wb_op_e;

    // one fifo entry, 42 bits
    typedef struct packed {
        wb_op_e             op;
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  data;
        logic [CID_W-1:0]   cid;
    } wb_entry_t;

endpackage

`default_nettype wire

//--- rtl/wb_result_fifo.sv
// per-lane writeback result fifo
`timescale 1ns/1ns
`default_nettype none

module wb_result_fifo (
    input wire        clk,
    input wire        rst_n,
    wb_fifo_if.fifo   f
);
    import wb_pkg::*;

    wb_entry_t          mem [FIFO_DEPTH];  // circular buffer
    logic [PTR_W-1:0]   wr_ptr;            // next free slot
    logic [PTR_W-1:0]   rd_ptr;            // current head
    logic [CNT_W-1:0]   count;             // occupancy

    // pointer advance with wrap at depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] nxt;
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = p + PTR_W'(1);
        end
        return nxt;
    endfunction

    // pointers and count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (f.push) wr_ptr <= ptr_inc(wr_ptr);
            if (f.pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({f.push, f.pop})
                2'b10:   count <= count + CNT_W'(1);  // fill
                2'b01:   count <= count - CNT_W'(1);  // drain
                default: count <= count;              // idle or push+pop
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (f.push) begin
            mem[wr_ptr] <= f.push_entry;  // slot freed same cycle if full+pop
        end
    end

    // status
    assign f.full  = (count == CNT_W'(FIFO_DEPTH));
    assign f.empty = (count == '0);

    // head reads zero when empty
    assign f.head_entry = f.empty ? '0 : mem[rd_ptr];

    // dispatcher must not overrun the lane
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (f.push && f.full) |-> f.pop
    ) else $error("lane fifo push while full without pop");

    // arbiter must not pop a drained lane
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(f.pop && f.empty)
    ) else $error("lane fifo pop while empty");

endmodule

`default_nettype wire

//--- rtl/wb_top.sv
// register writeback stage top
`timescale 1ns/1ns
`default_nettype none

module wb_top (
    input  wire                          clk,
    input  wire                          rst_n,

    // result stream from the execution lanes
    input  wire                          res_valid_i,
    input  wire [wb_pkg::LANE_W-1:0]     res_lane_i,
    input  wire wb_pkg::wb_op_e          res_op_i,
    input  wire [wb_pkg::ADDR_W-1:0]     res_addr_i,
    input  wire [wb_pkg::DATA_W-1:0]     res_data_i,
    input  wire [wb_pkg::CID_W-1:0]      res_cid_i,
    output wire                          res_stall_o,

    // in-order writeback port
    output wire                          wb_valid_o,
    output wire                          wb_we_o,
    output wire [wb_pkg::ADDR_W-1:0]     wb_addr_o,
    output wire [wb_pkg::DATA_W-1:0]     wb_data_o,
    output wire [wb_pkg::CID_W-1:0]      wb_cid_o
);
    import wb_pkg::*;

    wb_fifo_if lane_if [NUM_LANES] ();  // one bundle per lane

    // steer results into lanes
    wb_dispatch i_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid_i (res_valid_i),
        .res_lane_i  (res_lane_i),
        .res_op_i    (res_op_i),
        .res_addr_i  (res_addr_i),
        .res_data_i  (res_data_i),
        .res_cid_i   (res_cid_i),
        .res_stall_o (res_stall_o),
        .lanes       (lane_if)
    );

    // lane fifos
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_fifo
        wb_result_fifo i_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .f     (lane_if[g])
        );
    end

    // retire in commit id order
    wb_commit_arbiter i_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .lanes      (lane_if),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .wb_cid_o   (wb_cid_o)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# compile and run the writeback stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f build.f --top-module tb_wb_top \
    -Mdir "$OBJ" -o sim_wb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/sim_wb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0

//--- test/tb_wb_top.sv
// writeback stage testbench
`timescale 1ns/1ns
`default_nettype none

module tb_wb_top;
    import wb_pkg::*;

    logic clk;
    logic rst_n;
    logic res_valid_i;
    logic [LANE_W-1:0] res_lane_i;
    wb_op_e res_op_i;
    logic [ADDR_W-1:0] res_addr_i;
    logic [DATA_W-1:0] res_data_i;
    logic [CID_W-1:0] res_cid_i;
    logic res_stall_o;
    logic wb_valid_o;
    logic wb_we_o;
    logic [ADDR_W-1:0] wb_addr_o;
    logic [DATA_W-1:0] wb_data_o;
    logic [CID_W-1:0] wb_cid_o;

    // stimulus table with one row per result
    logic [LANE_W-1:0] row_lane [32];
    wb_op_e            row_op   [32];
    logic [ADDR_W-1:0] row_addr [32];
    logic [DATA_W-1:0] row_data [32];
    logic [CID_W-1:0]  row_cid  [32];
    bit                row_stall [32];   // row must meet back-pressure
    int                n_rows;
    string             grp_name  [3];
    int                grp_first [3];
    int                grp_count [3];

    int exp_q [$];               // row indices in commit order
    logic [CID_W-1:0] exp_next;  // model of the commit counter
    int errors;
    int checks;
    int beats;
    bit timed_out;
    string cur_test;
    integer seed;

    wb_top i_wb_top (.*);

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic add_row(input logic [LANE_W-1:0] lane, input wb_op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [CID_W-1:0] cid,
                           input bit stall);
        row_lane[n_rows]  = lane;
        row_op[n_rows]    = op;
        row_addr[n_rows]  = addr;
        row_data[n_rows]  = $random(seed);   // payload only needs to be unique-ish
        row_cid[n_rows]   = cid;
        row_stall[n_rows] = stall;
        n_rows++;
    endtask

    task automatic build_table();
        int m;
        // ids 0..5 scattered over lanes with two no-write ops
        grp_name[0] = "in_order";
        grp_first[0] = n_rows;
        add_row(2'd1, WB_OP_WRITE,   5'd2,  4'd2, 1'b0);
        add_row(2'd0, WB_OP_NOWRITE, 5'd1,  4'd1, 1'b0);
        add_row(2'd2, WB_OP_WRITE,   5'd3,  4'd0, 1'b0);
        add_row(2'd1, WB_OP_WRITE,   5'd4,  4'd3, 1'b0);
        add_row(2'd2, WB_OP_NOWRITE, 5'd5,  4'd5, 1'b0);
        add_row(2'd0, WB_OP_WRITE,   5'd6,  4'd4, 1'b0);
        grp_count[0] = n_rows - grp_first[0];
        // id 6 held back while lane 1 fills with 7 and 8
        grp_name[1] = "back_pressure";
        grp_first[1] = n_rows;
        add_row(2'd1, WB_OP_WRITE,   5'd7,  4'd7, 1'b0);
        add_row(2'd1, WB_OP_NOWRITE, 5'd0,  4'd8, 1'b0);
        add_row(2'd0, WB_OP_WRITE,   5'd11, 4'd6, 1'b0);
        add_row(2'd1, WB_OP_WRITE,   5'd9,  4'd9, 1'b1);  // lane 1 full here
        add_row(2'd2, WB_OP_WRITE,   5'd10, 4'd10, 1'b0);
        grp_count[1] = n_rows - grp_first[1];
        // 18 ids from 11 across the wrap with pairs swapped
        grp_name[2] = "wrap";
        grp_first[2] = n_rows;
        for (int j = 0; j < 9; j++) begin
            for (int k = 1; k >= 0; k--) begin
                m = 2 * j + k;
                add_row(LANE_W'(m % 3), (m % 4 == 3) ? WB_OP_NOWRITE : WB_OP_WRITE,
                        ADDR_W'(m + 12), CID_W'(11 + m), 1'b0);
            end
        end
        grp_count[2] = n_rows - grp_first[2];
    endtask

    // order a group's rows by expected commit id
    // a reused id after the wrap takes the next unqueued row in table order
    task automatic queue_group(input int g);
        bit found;
        bit used [32];   // rows already queued
        for (int j = 0; j < grp_count[g]; j++) begin
            found = 0;
            for (int r = grp_first[g]; r < grp_first[g] + grp_count[g]; r++) begin
                if (row_cid[r] == exp_next && !used[r] && !found) begin
                    exp_q.push_back(r);
                    used[r] = 1;
                    found = 1;
                end
            end
            if (!found) begin
                errors++;
                $display("stimulus table has no row with commit id %0d", exp_next);
            end
            exp_next = exp_next + CID_W'(1);   // wraps like the arbiter
        end
    endtask

    // entered and left 5 ns after a rising edge
    task automatic drive_row(input int r);
        int waits;
        bit seen;
        bit done;
        waits = 0;
        seen = 0;
        done = 0;
        res_valid_i = 1'b1;
        res_lane_i  = row_lane[r];
        res_op_i    = row_op[r];
        res_addr_i  = row_addr[r];
        res_data_i  = row_data[r];
        res_cid_i   = row_cid[r];
        while (!done && !timed_out) begin
            @(negedge clk);
            if (!res_stall_o) begin
                done = 1;                  // accepted on the coming edge
            end else begin
                seen = 1;
                waits++;
                if (waits > 50) begin
                    errors++;
                    timed_out = 1;
                    $display("timeout: result with commit id %0d stalled for %0d cycles",
                             row_cid[r], waits);
                end
            end
            @(posedge clk);
            #5;
        end
        if (row_stall[r]) check($sformatf("%s stall cid %0d", cur_test, row_cid[r]),
                                32'(1'b1), 32'(seen));
    endtask

    task automatic wait_drain();
        int waits;
        waits = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            waits++;
            if (waits > 100) begin
                errors++;
                timed_out = 1;
                $display("timeout: %0d results never retired", exp_q.size());
            end
        end
        @(posedge clk);
        #5;
    endtask

    task automatic check_idle(input string tag);
        check({tag, " wb_valid"}, 32'(1'b0), 32'(wb_valid_o));
        check({tag, " wb_we"}, 32'(1'b0), 32'(wb_we_o));
        check({tag, " res_stall"}, 32'(1'b0), 32'(res_stall_o));
    endtask

    // scoreboard sampling at the falling edge where outputs are stable
    always @(negedge clk) begin : monitor
        int r;
        if (rst_n && wb_valid_o) begin
            beats++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected writeback beat with commit id %0d, nothing pending",
                         wb_cid_o);
            end else begin
                r = exp_q.pop_front();
                check({cur_test, " cid"}, 32'(row_cid[r]), 32'(wb_cid_o));
                check($sformatf("%s we cid %0d", cur_test, row_cid[r]),
                      32'(row_op[r] == WB_OP_WRITE), 32'(wb_we_o));
                check($sformatf("%s addr cid %0d", cur_test, row_cid[r]),
                      32'(row_addr[r]), 32'(wb_addr_o));
                check($sformatf("%s data cid %0d", cur_test, row_cid[r]),
                      row_data[r], wb_data_o);
            end
        end
    end

    initial begin
        int err0;
        clk = 1'b0;
        rst_n = 1'b0;
        res_valid_i = 1'b0;
        res_lane_i = '0;
        res_op_i = WB_OP_WRITE;
        res_addr_i = '0;
        res_data_i = '0;
        res_cid_i = '0;
        errors = 0;
        checks = 0;
        beats = 0;
        timed_out = 0;
        n_rows = 0;
        exp_next = '0;
        seed = 32'ha554;
        build_table();

        cur_test = "reset";
        repeat (5) begin
            @(negedge clk);
            check_idle("reset during");
        end
        @(posedge clk);
        #5 rst_n = 1'b1;
        @(negedge clk);
        check_idle("reset after");
        $display("test reset: %0d errors", errors);
        @(posedge clk);
        #5;

        for (int g = 0; g < 3 && !timed_out; g++) begin
            cur_test = grp_name[g];
            err0 = errors;
            queue_group(g);
            for (int r = grp_first[g]; r < grp_first[g] + grp_count[g] && !timed_out; r++) begin
                drive_row(r);
            end
            res_valid_i = 1'b0;
            wait_drain();
            $display("test %s: %0d results, %0d errors", cur_test, grp_count[g], errors - err0);
        end

        // quiet window where no stray beat may appear
        cur_test = "drain";
        err0 = errors;
        repeat (20) @(posedge clk);
        check("drain beat count", n_rows, beats);
        check("drain pending", 0, exp_q.size());
        $display("test drain: %0d errors", errors - err0);

        $display("tests 5, checks %0d, beats %0d, errors %0d", checks, beats, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
